/* files.f */
hdl/drePkg.sv
hdl/dreStageIf.sv
hdl/dualPortRam.sv
hdl/dreRequestStage.sv
hdl/dreMergeStage.sv
hdl/dreCommitStage.sv
hdl/cacheDreTop.sv
tests/cacheDreTb.sv

/* hdl/cacheDreTop.sv */
// byte-readable store top
`timescale 1ns/1ns

module cacheDreTop (
  input  logic              clk,
  input  logic              arstN,
  input  logic              reqValid,
  input  drePkg::dreOpE     reqOp,
  input  drePkg::dreAddrT   reqAddr,
  input  drePkg::dreWayT    reqWay,
  input  drePkg::dreMaskT   reqMask,
  input  drePkg::dreEntryT  reqData,
  output logic              rspValid,
  output drePkg::dreMaskT   rspRe,
  output drePkg::dreEntryT  rspAll
);

  // ram read side.
  drePkg::dreLineT                  ramReadAddress;
  logic [drePkg::dreWays*8-1:0]     ramReadData;
  // ram write side.
  drePkg::dreLineT                  ramWriteAddress;
  logic [drePkg::dreWays*8-1:0]     ramWriteData;
  logic [drePkg::dreWays-1:0]       ramWriteByteEnable;
  logic                             ramWriteEnable;

  // stage links.
  dreStageIf #(.payloadT(drePkg::dreReqT))   s1If ();
  dreStageIf #(.payloadT(drePkg::dreEntryT)) s2If ();
  dreStageIf #(.payloadT(drePkg::dreEntryT)) lwIf ();

  dreRequestStage reqStage (
    .clk(clk), .arstN(arstN),
    .reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr),
    .reqWay(reqWay), .reqMask(reqMask), .reqData(reqData),
    .ramReadAddress(ramReadAddress), .s1(s1If)
  );

  // s2 also tapped as the newest forwarding source.
  dreMergeStage mergeStage (
    .clk(clk), .arstN(arstN), .ramReadData(ramReadData),
    .s1(s1If), .s2(s2If), .s2Mon(s2If), .lw(lwIf)
  );

  dreCommitStage commitStage (
    .clk(clk), .arstN(arstN), .s2(s2If), .lw(lwIf),
    .ramWriteAddress(ramWriteAddress), .ramWriteData(ramWriteData),
    .ramWriteByteEnable(ramWriteByteEnable), .ramWriteEnable(ramWriteEnable),
    .rspValid(rspValid), .rspRe(rspRe), .rspAll(rspAll)
  );

  // one byte lane per way, one row per word pair.
  dualPortRam #(.wordBytes(drePkg::dreWays), .depth(2**drePkg::dreLineWidth)) rowRam (
    .clk(clk),
    .readAddress(ramReadAddress), .readData(ramReadData),
    .writeAddress(ramWriteAddress), .writeData(ramWriteData),
    .writeEnable(ramWriteEnable), .writeByteEnable(ramWriteByteEnable)
  );

endmodule

/* hdl/dreCommitStage.sv */
// write back and response stage
`timescale 1ns/1ns

module dreCommitStage (
  input  logic                                      clk,
  input  logic                                      arstN,
  dreStageIf.consumer                               s2,
  dreStageIf.producer                               lw,
  output drePkg::dreLineT                           ramWriteAddress,
  output logic [drePkg::dreWays*8-1:0]              ramWriteData,
  output logic [drePkg::dreWays-1:0]                ramWriteByteEnable,
  output logic                                      ramWriteEnable,
  output logic                                      rspValid,
  output drePkg::dreMaskT                           rspRe,
  output drePkg::dreEntryT                          rspAll
);

  // store or refill in stage two.
  logic isWrite;
  // query in stage two.
  logic isQuery;

  assign isWrite = s2.valid && (s2.op != drePkg::opQuery);
  assign isQuery = s2.valid && (s2.op == drePkg::opQuery);

  // write port driven straight from stage two.
  // the ram takes it on the next edge.
  assign ramWriteEnable     = isWrite;
  assign ramWriteAddress    = s2.addr[drePkg::dreAddrWidth-1:1];
  // entry copied to every lane and the way picks one.
  assign ramWriteData       = {drePkg::dreWays{s2.payload}};
  assign ramWriteByteEnable = {{(drePkg::dreWays-1){1'b0}}, 1'b1} << s2.way;

  // control flags.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lw.valid <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      lw.valid <= isWrite;
      rspValid <= isQuery;
    end
  end

  // last write record lives one cycle past the ram write.
  always_ff @(posedge clk) begin
    if (isWrite) begin
      lw.op      <= s2.op;
      lw.addr    <= s2.addr;
      lw.way     <= s2.way;
      lw.payload <= s2.payload;
    end
  end

  // query response.
  // half picked by word address bit 0.
  always_ff @(posedge clk) begin
    if (isQuery) begin
      rspAll <= s2.payload;
      rspRe  <= s2.payload[s2.addr[0]];
    end
  end

  // exactly one way per write.
  wayOneHot: assert property (
    @(posedge clk) disable iff (!arstN)
    ramWriteEnable |-> $onehot(ramWriteByteEnable)
  );

endmodule

/* hdl/dreMergeStage.sv */
// entry select and merge stage
`timescale 1ns/1ns

module dreMergeStage (
  input  logic                                      clk,
  input  logic                                      arstN,
  input  drePkg::dreEntryT [drePkg::dreWays-1:0]    ramReadData,
  dreStageIf.consumer                               s1,
  dreStageIf.producer                               s2,
  dreStageIf.monitor                                s2Mon,
  dreStageIf.monitor                                lw
);

  // row of the stage one request.
  drePkg::dreLineT  rowS1;
  // forwarding hits.
  logic             hitS2;
  logic             hitLw;
  // entry before and after the operation.
  drePkg::dreEntryT curEntry;
  drePkg::dreEntryT newEntry;

  assign rowS1 = s1.addr[drePkg::dreAddrWidth-1:1];

  // stage two is newest, but only a write changes the entry.
  assign hitS2 = s2Mon.valid && (s2Mon.op != drePkg::opQuery) &&
                 (s2Mon.addr[drePkg::dreAddrWidth-1:1] == rowS1) &&
                 (s2Mon.way == s1.way);

  // write committed on the last edge, ram read missed it.
  assign hitLw = lw.valid &&
                 (lw.addr[drePkg::dreAddrWidth-1:1] == rowS1) &&
                 (lw.way == s1.way);

  // priority stage two, then last write, then ram.
  always_comb begin
    if (hitS2) begin
      curEntry = s2Mon.payload;
    end else if (hitLw) begin
      curEntry = lw.payload;
    end else begin
      curEntry = ramReadData[s1.way];
    end
  end

  // apply the operation.
  always_comb begin
    newEntry = curEntry;
    case (s1.op)
      drePkg::opRefill: newEntry = s1.payload.data;
      // or the mask into the addressed half only.
      drePkg::opStore: newEntry[s1.addr[0]] = curEntry[s1.addr[0]] | s1.payload.mask;
      default: newEntry = curEntry;
    endcase
  end

  // stage two valid.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s2.valid <= 1'b0;
    end else begin
      s2.valid <= s1.valid;
    end
  end

  // stage two fields and merged entry.
  always_ff @(posedge clk) begin
    if (s1.valid) begin
      s2.op      <= s1.op;
      s2.addr    <= s1.addr;
      s2.way     <= s1.way;
      s2.payload <= newEntry;
    end
  end

  // an empty store mask would be a wasted write.
  storeMaskSet: assert property (
    @(posedge clk) disable iff (!arstN)
    (s1.valid && (s1.op == drePkg::opStore)) |-> (s1.payload.mask != '0)
  );

endmodule

/* hdl/drePkg.sv */
// byte-readable tracking types
package drePkg;

  // word address width.
  localparam int dreAddrWidth = 6;
  // row address, one row per word pair.
  localparam int dreLineWidth = dreAddrWidth - 1;
  // ways in the set.
  localparam int dreWays = 4;

  // word address, bit 0 picks the entry half.
  typedef logic [dreAddrWidth-1:0] dreAddrT;
  // row address into the ram.
  typedef logic [dreLineWidth-1:0] dreLineT;
  // way index.
  typedef logic [$clog2(dreWays)-1:0] dreWayT;
  // one readable bit per byte of a word.
  typedef logic [3:0] dreMaskT;
  // entry of one way, half 1 is the odd word.
  typedef dreMaskT [1:0] dreEntryT;

  // request opcodes.
  typedef enum logic [1:0] {
    opQuery,
    opStore,
    opRefill
  } dreOpE;

  // stage one payload.
  // mask feeds a store, data feeds a refill.
  typedef struct packed {
    dreMaskT  mask;
    dreEntryT data;
  } dreReqT;

endpackage

/* hdl/dreRequestStage.sv */
// request capture stage
`timescale 1ns/1ns

module dreRequestStage (
  input  logic              clk,
  input  logic              arstN,
  input  logic              reqValid,
  input  drePkg::dreOpE     reqOp,
  input  drePkg::dreAddrT   reqAddr,
  input  drePkg::dreWayT    reqWay,
  input  drePkg::dreMaskT   reqMask,
  input  drePkg::dreEntryT  reqData,
  output drePkg::dreLineT   ramReadAddress,
  dreStageIf.producer       s1
);

  // row read launches on the same edge the request is taken.
  // ram data then lines up with stage one.
  assign ramReadAddress = reqAddr[drePkg::dreAddrWidth-1:1];

  // stage one valid.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1.valid <= 1'b0;
    end else begin
      s1.valid <= reqValid;
    end
  end

  // request fields.
  // held while idle.
  always_ff @(posedge clk) begin
    if (reqValid) begin
      s1.op   <= reqOp;
      s1.addr <= reqAddr;
      s1.way  <= reqWay;
    end
  end

  // payload.
  // mask only matters for a store, data only for a refill.
  always_ff @(posedge clk) begin
    if (reqValid) begin
      s1.payload.mask <= reqMask;
      s1.payload.data <= reqData;
    end
  end

  // opcode must be known on a live request.
  reqOpKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    reqValid |-> !$isunknown(reqOp)
  );

endmodule

/* hdl/dreStageIf.sv */
// pipeline stage link
`timescale 1ns/1ns

interface dreStageIf #(
  parameter type payloadT = drePkg::dreEntryT
) ();

  // register holds a live request.
  logic valid;
  // request opcode.
  drePkg::dreOpE op;
  // word address of the request.
  drePkg::dreAddrT addr;
  // addressed way.
  drePkg::dreWayT way;
  // stage specific payload.
  payloadT payload;

  // owning stage drives everything.
  modport producer (output valid, op, addr, way, payload);

  // next stage reads the request.
  modport consumer (input valid, op, addr, way, payload);

  // forwarding taps.
  modport monitor (input valid, op, addr, way, payload);

endinterface

/* hdl/dualPortRam.sv */
// byte-enabled dual port ram
`timescale 1ns/1ns

module dualPortRam #(
  parameter int wordBytes = 4,
  parameter int depth = 32
) (
  input  logic                         clk,
  input  logic [$clog2(depth)-1:0]     readAddress,
  output logic [8*wordBytes-1:0]       readData,
  input  logic [$clog2(depth)-1:0]     writeAddress,
  input  logic [8*wordBytes-1:0]       writeData,
  input  logic                         writeEnable,
  input  logic [wordBytes-1:0]         writeByteEnable
);

  // storage, contents undefined until written.
  logic [8*wordBytes-1:0] mem [depth];

  // byte lane writes.
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      for (int b = 0; b < wordBytes; b++) begin
        // only enabled lanes change.
        if (writeByteEnable[b]) begin
          mem[writeAddress][8*b +: 8] <= writeData[8*b +: 8];
        end
      end
    end
  end

  // registered read.
  // same row written this edge returns old data.
  always_ff @(posedge clk) begin
    readData <= mem[readAddress];
  end

  // a write must touch at least one lane.
  writeHasLane: assert property (
    @(posedge clk) writeEnable |-> (writeByteEnable != '0)
  );

endmodule

/* tests/cacheDreTb.sv */
// byte-readable store testbench
`timescale 1ns/1ns

module cacheDreTb;

  // refills, full query sweep, two store checks, two merge runs, random mix.
  localparam int plannedRequests = 128 + 256 + 2 * 9 + 2 * 6 + 400;

  logic              clk;
  logic              arstN;
  logic              reqValid;
  drePkg::dreOpE     reqOp;
  drePkg::dreAddrT   reqAddr;
  drePkg::dreWayT    reqWay;
  drePkg::dreMaskT   reqMask;
  drePkg::dreEntryT  reqData;
  logic              rspValid;
  drePkg::dreMaskT   rspRe;
  drePkg::dreEntryT  rspAll;

  // expected entry per row and way.
  drePkg::dreEntryT model [2**drePkg::dreLineWidth][drePkg::dreWays];
  // pending query expectations, oldest first.
  drePkg::dreMaskT  expRe [$];
  drePkg::dreEntryT expAll [$];
  int               expCycle [$];
  int               cycleCount = 0;
  int unsigned      lcgState = 49;

  cacheDreTop u_cacheDreTop (
    .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqOp(reqOp),
    .reqAddr(reqAddr), .reqWay(reqWay), .reqMask(reqMask), .reqData(reqData),
    .rspValid(rspValid), .rspRe(rspRe), .rspAll(rspAll)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // edges seen so far.
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  function automatic int unsigned lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 8;
  endfunction

  // expected whole entry of the addressed way.
  function automatic drePkg::dreEntryT refEntry(drePkg::dreAddrT addr, drePkg::dreWayT way);
    return model[addr[drePkg::dreAddrWidth-1:1]][way];
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic checkMask(input string name, input drePkg::dreMaskT got, drePkg::dreMaskT exp);
    if (got !== exp) begin
      abortRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkEntry(input string name, input drePkg::dreEntryT got,
                            input drePkg::dreEntryT exp);
    if (got !== exp) begin
      abortRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // issues one request and updates the model in issue order.
  task automatic issueRequest(input drePkg::dreOpE op, input drePkg::dreAddrT addr,
                              input drePkg::dreWayT way, input drePkg::dreMaskT mask,
                              input drePkg::dreEntryT data);
    drePkg::dreLineT  row;
    drePkg::dreEntryT want;
    @(posedge clk);
    #2;
    reqValid = 1'b1;
    reqOp    = op;
    reqAddr  = addr;
    reqWay   = way;
    reqMask  = mask;
    reqData  = data;
    row = addr[drePkg::dreAddrWidth-1:1];
    if (op == drePkg::opRefill) begin
      model[row][way] = data;
    end else if (op == drePkg::opStore) begin
      model[row][way][addr[0]] = model[row][way][addr[0]] | mask;
    end else begin
      want = refEntry(addr, way);
      expAll.push_back(want);
      // upper half for an odd word.
      expRe.push_back(want[addr[0]]);
      // sampled on the next edge and visible two edges later.
      expCycle.push_back(cycleCount + 3);
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      reqValid = 1'b0;
    end
  endtask

  // refill, three stores and queries of both halves on one entry.
  task automatic mergeSequence(input drePkg::dreAddrT addr, input drePkg::dreWayT way,
                               input int gap);
    issueRequest(drePkg::opRefill, addr, way, 4'h0, 8'h00);
    idleCycles(gap);
    issueRequest(drePkg::opStore, addr, way, 4'h1, 8'h00);
    idleCycles(gap);
    issueRequest(drePkg::opStore, addr, way, 4'h2, 8'h00);
    idleCycles(gap);
    issueRequest(drePkg::opStore, addr, way, 4'h8, 8'h00);
    idleCycles(gap);
    issueRequest(drePkg::opQuery, addr, way, 4'h0, 8'h00);
    issueRequest(drePkg::opQuery, addr ^ 6'h01, way, 4'h0, 8'h00);
  endtask

  // pops one expectation per response.
  initial begin : compareResponses
    drePkg::dreMaskT  wantRe;
    drePkg::dreEntryT wantAll;
    int               wantCycle;
    wait (arstN === 1'b1);
    forever begin
      @(negedge clk);
      if (rspValid !== 1'b0 && rspValid !== 1'b1) begin
        abortRun("rspValid is unknown after reset");
      end else if (rspValid) begin
        if (expRe.size() == 0) begin
          abortRun("a response came with no query pending");
        end
        wantRe    = expRe.pop_front();
        wantAll   = expAll.pop_front();
        wantCycle = expCycle.pop_front();
        if (wantCycle != cycleCount) begin
          abortRun($sformatf("query response at cycle %0d, expected at cycle %0d",
                             cycleCount, wantCycle));
        end
        checkMask("rspRe", rspRe, wantRe);
        checkEntry("rspAll", rspAll, wantAll);
      end else if (expCycle.size() != 0 && expCycle[0] <= cycleCount) begin
        abortRun("a query response never arrived");
      end
    end
  end

  // room for random gaps plus drain.
  initial begin
    repeat (20 * plannedRequests + 200) @(posedge clk);
    abortRun("watchdog timeout, the run did not finish in time");
  end

  initial begin : mainSequence
    int unsigned r;
    arstN = 1'b0;
    reqValid = 1'b0;
    reqOp = drePkg::opQuery;
    reqAddr = '0;
    reqWay = '0;
    reqMask = '0;
    reqData = '0;
    repeat (2) @(posedge clk);
    #2;
    arstN = 1'b1;
    idleCycles(3);
    // fill every row and way.
    for (int row = 0; row < 32; row++) begin
      for (int way = 0; way < 4; way++) begin
        r = lcgNext();
        issueRequest(drePkg::opRefill, {row[4:0], 1'b0}, way[1:0], 4'h0, r[7:0]);
      end
    end
    for (int addr = 0; addr < 64; addr++) begin
      for (int way = 0; way < 4; way++) begin
        issueRequest(drePkg::opQuery, addr[5:0], way[1:0], 4'h0, 8'h00);
      end
    end
    // a store touches one half of one way.
    issueRequest(drePkg::opStore, 6'd13, 2'd2, 4'h5, 8'h00);
    for (int i = 0; i < 8; i++) begin
      issueRequest(drePkg::opQuery, {5'd6, i[0]}, i[2:1], 4'h0, 8'h00);
    end
    issueRequest(drePkg::opStore, 6'd20, 2'd0, 4'h8, 8'h00);
    for (int i = 0; i < 8; i++) begin
      issueRequest(drePkg::opQuery, {5'd10, i[0]}, i[2:1], 4'h0, 8'h00);
    end
    // stage two forwarding, then last write forwarding.
    mergeSequence(6'd33, 2'd1, 0);
    mergeSequence(6'd42, 2'd3, 1);
    // random mix on two rows.
    for (int i = 0; i < 400; i++) begin
      r = lcgNext();
      issueRequest(drePkg::dreOpE'(r % 3), 6'(lcgNext() % 4), 2'(lcgNext() % 4),
                   4'(lcgNext() % 15 + 1), 8'(lcgNext()));
      idleCycles(lcgNext() % 3);
    end
    idleCycles(6);
    if (expRe.size() != 0) begin
      abortRun($sformatf("%0d query responses still pending at the end", expRe.size()));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule
